/* verilog/l1c_pkg.sv */
package l1c_pkg;

// Address and data widths
localparam int ADDR_W    = 32;
localparam int WORD_W    = 32;

// Block geometry
localparam int OFS_W     = 4;                     // 16-byte blocks
localparam int IDX_W     = 6;                     // 64 sets
localparam int TAG_W     = ADDR_W - IDX_W - OFS_W;
localparam int BLK_WORDS = 4;

typedef logic [ADDR_W-1:0]   addr_t;
typedef logic [WORD_W-1:0]   word_t;
typedef logic [WORD_W/8-1:0] strb_t;
typedef logic [IDX_W-1:0]    idx_t;
typedef logic [TAG_W-1:0]    tag_t;
typedef logic [1:0]          wsel_t;              // Address bits 3:2

endpackage

/* verilog/sync_ram.sv */
`timescale 1ns/1ns

module sync_ram #(
    parameter type T = logic [31:0]
) (
    input  logic          clk,
    input  logic          en,
    input  logic          we,
    input  l1c_pkg::idx_t addr,
    input  T              din,
    output T              dout
);

import l1c_pkg::*;

T mem [2**IDX_W];

always_ff @(posedge clk) begin
    if (en) begin
        if (we) mem[addr] <= din;
        dout <= mem[addr];                            // Old contents on a write cycle
    end
end

a_addr_known: assert property (@(posedge clk) en |-> !$isunknown(addr));

endmodule

/* verilog/beat_counter.sv */
`timescale 1ns/1ns

module beat_counter (
    input  logic           clk,
    input  logic           rstn,
    input  logic           burst_start,
    input  l1c_pkg::wsel_t want_slot,
    input  logic           single,
    input  logic           rvalid,
    input  logic           rlast,
    output l1c_pkg::wsel_t beat_slot,
    output logic           want_beat
);

import l1c_pkg::*;

// Refill bursts start block aligned, so beat number is the word slot
always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        beat_slot <= '0;
    end
    else if (burst_start) begin
        beat_slot <= '0;
    end
    else if (rvalid) begin
        beat_slot <= beat_slot + wsel_t'(1);
    end
end

// A bypass read has one beat and it is always the wanted one
assign want_beat = single ? rvalid : (beat_slot == want_slot);

// Slave must end a refill burst on the last word of the block
a_rlast_slot: assert property (@(posedge clk) disable iff (~rstn)
    rvalid && rlast && !single |-> beat_slot == wsel_t'(BLK_WORDS - 1));

endmodule

/* verilog/l1c_ctrl.sv */
`timescale 1ns/1ns

module l1c_ctrl (
    input  logic           clk,
    input  logic           rstn,
    input  logic           core_req,
    input  logic           core_wr,
    input  logic           core_bypass,
    input  logic           hit,
    input  l1c_pkg::addr_t req_paddr,
    input  logic           m_arready,
    input  logic           m_rvalid,
    input  logic           m_rlast,
    input  logic [1:0]     m_rresp,
    input  logic           m_awready,
    input  logic           m_wready,
    input  logic           m_bvalid,
    input  logic [1:0]     m_bresp,
    output logic           m_arvalid,
    output l1c_pkg::addr_t m_araddr,
    output logic [7:0]     m_arlen,
    output logic           m_awvalid,
    output l1c_pkg::addr_t m_awaddr,
    output logic           m_wvalid,
    output logic           accept,
    output logic           refill_we,
    output logic           fill_done,
    output logic           store_we,
    output logic           rdata_from_bus,
    output logic           burst_start,
    output logic           single,
    output logic           core_busy,
    output logic [1:0]     core_bad
);

import l1c_pkg::*;

typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_MREQ,
    S_REFILL,
    S_BYPASS,
    S_WRITE
} state_t;

state_t state;
state_t state_nxt;
state_t route;
logic   ar_pend;                                     // Bypass AR not yet taken
logic   aw_pend;
logic   w_pend;
logic   wr_first;
logic   err_q;
logic   r_end;

assign accept = core_req && (state == S_IDLE || (state == S_LOOKUP && hit));
assign route  = core_wr ? S_WRITE : core_bypass ? S_BYPASS : S_LOOKUP;
assign r_end  = m_rvalid && m_rlast;

always_comb begin
    state_nxt = state;
    case (state)
        S_IDLE:   if (accept) state_nxt = route;
        S_LOOKUP: state_nxt = !hit ? S_MREQ : accept ? route : S_IDLE;
        S_MREQ:   if (m_arready) state_nxt = S_REFILL;
        S_REFILL: if (r_end) state_nxt = S_IDLE;
        S_BYPASS: if (r_end) state_nxt = S_IDLE;
        S_WRITE:  if (m_bvalid) state_nxt = S_IDLE;
        default:  state_nxt = S_IDLE;
    endcase
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) state <= S_IDLE;
    else       state <= state_nxt;
end

// Per-channel valids, each drops on its own ready
always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        ar_pend  <= 1'b0;
        aw_pend  <= 1'b0;
        w_pend   <= 1'b0;
        wr_first <= 1'b0;
    end
    else begin
        wr_first <= accept && core_wr;
        if (accept) begin
            ar_pend <= !core_wr && core_bypass;
            aw_pend <= core_wr;
            w_pend  <= core_wr;
        end
        else begin
            if (m_arready) ar_pend <= 1'b0;
            if (m_awready) aw_pend <= 1'b0;
            if (m_wready)  w_pend  <= 1'b0;
        end
    end
end

// Error record and read-data source for the finished access
always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        err_q          <= 1'b0;
        rdata_from_bus <= 1'b0;
    end
    else if (accept) begin
        err_q          <= 1'b0;
        rdata_from_bus <= 1'b0;
    end
    else begin
        if ((m_rvalid && m_rresp[1]) || (m_bvalid && m_bresp[1])) err_q <= 1'b1;
        if ((state == S_REFILL || state == S_BYPASS) && r_end) rdata_from_bus <= 1'b1;
    end
end

assign core_bad  = {err_q, 1'b0};
assign core_busy = (state == S_LOOKUP) ? !hit : (state != S_IDLE);

assign m_arvalid = (state == S_MREQ) || (state == S_BYPASS && ar_pend);
assign m_araddr  = (state == S_BYPASS) ? req_paddr
                                       : {req_paddr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
assign m_arlen   = (state == S_MREQ) ? 8'(BLK_WORDS - 1) : 8'd0;
assign m_awvalid = aw_pend;
assign m_awaddr  = req_paddr;
assign m_wvalid  = w_pend;

assign burst_start = m_arvalid && m_arready;
assign single      = (state == S_BYPASS);
assign refill_we   = (state == S_REFILL) && m_rvalid;
assign fill_done   = (state == S_REFILL) && r_end;
assign store_we    = wr_first && hit;                 // Merge into the cached word on a hit

a_ar_hold: assert property (@(posedge clk) disable iff (~rstn)
    m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr));

a_store_first: assert property (@(posedge clk) disable iff (~rstn)
    store_we |-> state == S_WRITE && $past(state) != S_WRITE);

endmodule

/* verilog/l1c_datapath.sv */
`timescale 1ns/1ns

module l1c_datapath (
    input  logic            clk,
    input  logic            rstn,
    input  l1c_pkg::addr_t  core_vaddr,
    input  l1c_pkg::addr_t  core_paddr,
    input  l1c_pkg::word_t  core_wdata,
    input  l1c_pkg::strb_t  core_byte,
    input  logic            core_flush,
    input  logic            accept,
    input  logic            refill_we,
    input  logic            fill_done,
    input  logic            store_we,
    input  logic            rdata_from_bus,
    input  logic            fill_ok,
    input  l1c_pkg::wsel_t  beat_slot,
    input  logic            want_beat,
    input  l1c_pkg::word_t  m_rdata,
    input  logic            m_rvalid,
    output logic            hit,
    output l1c_pkg::addr_t  req_paddr,
    output l1c_pkg::word_t  m_wdata,
    output l1c_pkg::strb_t  m_wstrb,
    output l1c_pkg::word_t  core_rdata
);

import l1c_pkg::*;

addr_t              vaddr_q;
word_t              bus_q;
logic [2**IDX_W-1:0] valid;
logic               fill_q;
idx_t               req_idx;
idx_t               ram_idx;
wsel_t              req_wsel;
tag_t               tag_out;
word_t              word_out [BLK_WORDS];
word_t              merged;

assign req_idx  = vaddr_q[OFS_W +: IDX_W];
assign req_wsel = vaddr_q[OFS_W-1:2];
assign ram_idx  = accept ? core_vaddr[OFS_W +: IDX_W] : req_idx;   // Virtual index

always_ff @(posedge clk) begin
    if (accept) begin
        vaddr_q   <= core_vaddr;
        req_paddr <= core_paddr;
        m_wdata   <= core_wdata;
        m_wstrb   <= core_byte;
    end
    if (m_rvalid && want_beat) bus_q <= m_rdata;
end

// Valid bit lands a cycle after the last beat, once its response is recorded
always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        valid  <= '0;
        fill_q <= 1'b0;
    end
    else begin
        fill_q <= fill_done;
        if (core_flush)  valid <= '0;
        else if (fill_q) valid[req_idx] <= fill_ok;
    end
end

assign hit = valid[req_idx] && (tag_out == req_paddr[ADDR_W-1 -: TAG_W]);

sync_ram #(.T(tag_t)) u_tag (
    .clk  ( clk                          ),
    .en   ( accept || fill_done          ),
    .we   ( fill_done                    ),
    .addr ( ram_idx                      ),
    .din  ( req_paddr[ADDR_W-1 -: TAG_W] ),
    .dout ( tag_out                      )
);

// Byte merge of the store into the word read at acceptance
always_comb begin
    merged = word_out[req_wsel];
    for (int b = 0; b < WORD_W/8; b++) begin
        if (m_wstrb[b]) merged[b*8 +: 8] = m_wdata[b*8 +: 8];
    end
end

for (genvar i = 0; i < BLK_WORDS; i++) begin : g_word
    logic wr;
    assign wr = (refill_we && beat_slot == wsel_t'(i)) || (store_we && req_wsel == wsel_t'(i));
    sync_ram #(.T(word_t)) u_word (
        .clk  ( clk                         ),
        .en   ( accept || wr                ),
        .we   ( wr                          ),
        .addr ( ram_idx                     ),
        .din  ( refill_we ? m_rdata : merged ),
        .dout ( word_out[i]                 )
    );
end

assign core_rdata = rdata_from_bus ? bus_q : word_out[req_wsel];

endmodule

/* verilog/l1c.sv */
`timescale 1ns/1ns

module l1c (
    input  logic           clk,
    input  logic           rstn,
    // Core side
    input  logic           core_req,
    input  logic           core_wr,
    input  logic           core_bypass,
    input  logic           core_flush,
    input  l1c_pkg::addr_t core_vaddr,
    input  l1c_pkg::addr_t core_paddr,
    input  l1c_pkg::word_t core_wdata,
    input  l1c_pkg::strb_t core_byte,
    output l1c_pkg::word_t core_rdata,
    output logic [1:0]     core_bad,              // [1] bus error
    output logic           core_busy,
    // Memory bus
    output l1c_pkg::addr_t m_araddr,
    output logic [7:0]     m_arlen,
    output logic           m_arvalid,
    input  logic           m_arready,
    input  l1c_pkg::word_t m_rdata,
    input  logic [1:0]     m_rresp,
    input  logic           m_rlast,
    input  logic           m_rvalid,
    output l1c_pkg::addr_t m_awaddr,
    output logic           m_awvalid,
    input  logic           m_awready,
    output l1c_pkg::word_t m_wdata,
    output l1c_pkg::strb_t m_wstrb,
    output logic           m_wvalid,
    input  logic           m_wready,
    input  logic [1:0]     m_bresp,
    input  logic           m_bvalid
);

import l1c_pkg::*;

logic  accept;
logic  refill_we;
logic  fill_done;
logic  store_we;
logic  rdata_from_bus;
logic  burst_start;
logic  single;
logic  hit;
logic  fill_ok;
logic  want_beat;
addr_t req_paddr;
wsel_t beat_slot;
wsel_t want_slot;

assign fill_ok   = ~core_bad[1];
assign want_slot = req_paddr[OFS_W-1:2];

l1c_ctrl u_ctrl (
    .clk, .rstn,
    .core_req, .core_wr, .core_bypass, .hit, .req_paddr,
    .m_arready, .m_rvalid, .m_rlast, .m_rresp, .m_awready, .m_wready, .m_bvalid, .m_bresp,
    .m_arvalid, .m_araddr, .m_arlen, .m_awvalid, .m_awaddr, .m_wvalid,
    .accept, .refill_we, .fill_done, .store_we, .rdata_from_bus,
    .burst_start, .single, .core_busy, .core_bad
);

beat_counter u_beat (
    .clk, .rstn,
    .burst_start, .want_slot, .single,
    .rvalid ( m_rvalid ),
    .rlast  ( m_rlast  ),
    .beat_slot, .want_beat
);

l1c_datapath u_dp (
    .clk, .rstn,
    .core_vaddr, .core_paddr, .core_wdata, .core_byte, .core_flush,
    .accept, .refill_we, .fill_done, .store_we, .rdata_from_bus, .fill_ok,
    .beat_slot, .want_beat,
    .m_rdata, .m_rvalid,
    .hit, .req_paddr, .m_wdata, .m_wstrb, .core_rdata
);

endmodule

/* bench/axi_mem_slave.sv */
`timescale 1ns/1ns

module axi_mem_slave #(
    parameter logic [15:0] SEED = 16'd36
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid
);

logic [7:0]  mem [4096];                              // Byte addressed, 4 KiB window
logic [15:0] lfsr;
logic [7:0]  coin;
logic [31:0] rd_addr;                                 // Last AR address
logic [7:0]  rd_len;
logic [7:0]  rd_beat;
logic        rd_busy;
logic [31:0] wr_addr;                                 // Last AW address
logic [31:0] wr_data;
logic [3:0]  wr_strb;
logic        aw_done;
logic        w_done;
int          ar_count;
int          err_count;

function automatic logic [31:0] word_at(input logic [11:0] b);
    return {mem[b + 12'd3], mem[b + 12'd2], mem[b + 12'd1], mem[b]};
endfunction

task automatic draw(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        v = {v[6:0], lfsr[0]};
    end
endtask

always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        lfsr = SEED;
        for (int a = 0; a < 4096; a++) begin
            mem[a] <= 8'(a) ^ 8'(a >> 8) ^ 8'h5a;    // Pattern over all 12 address bits
        end
        arready   <= 1'b0;
        rvalid    <= 1'b0;
        rlast     <= 1'b0;
        rresp     <= 2'b00;
        rdata     <= '0;
        awready   <= 1'b0;
        wready    <= 1'b0;
        bvalid    <= 1'b0;
        bresp     <= 2'b00;
        rd_busy   <= 1'b0;
        rd_addr   <= '0;
        rd_len    <= '0;
        rd_beat   <= '0;
        wr_addr   <= '0;
        wr_data   <= '0;
        wr_strb   <= '0;
        aw_done   <= 1'b0;
        w_done    <= 1'b0;
        ar_count  <= 0;
        err_count <= 0;
    end
    else begin
        if (arvalid && arready) begin
            arready  <= 1'b0;
            rd_busy  <= 1'b1;
            rd_addr  <= araddr;
            rd_len   <= arlen;
            rd_beat  <= '0;
            ar_count <= ar_count + 1;
        end
        else begin
            draw(2, coin);
            arready <= arvalid && !rd_busy && coin[1:0] != 2'b00;
        end

        // One R beat per cycle at most, with random gaps
        if (rvalid && rlast) begin
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rd_busy <= 1'b0;
        end
        else if (rd_busy && rd_beat <= rd_len) begin
            draw(2, coin);
            if (coin[1:0] != 2'b00) begin
                rvalid  <= 1'b1;
                rdata   <= word_at(rd_addr[11:0] + {8'd0, rd_beat[1:0], 2'b00});
                rlast   <= rd_beat == rd_len;
                rd_beat <= rd_beat + 8'd1;
                draw(4, coin);
                rresp   <= (coin[3:0] == 4'd0) ? 2'b10 : 2'b00;
                if (coin[3:0] == 4'd0) err_count <= err_count + 1;
            end
            else begin
                rvalid <= 1'b0;
            end
        end

        if (awvalid && awready) begin
            awready <= 1'b0;
            aw_done <= 1'b1;
            wr_addr <= awaddr;
        end
        else begin
            draw(1, coin);
            awready <= awvalid && !aw_done && coin[0];
        end

        if (wvalid && wready) begin
            wready  <= 1'b0;
            w_done  <= 1'b1;
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
        else begin
            draw(1, coin);
            wready <= wvalid && !w_done && coin[0];
        end

        if (bvalid) begin
            bvalid <= 1'b0;
        end
        else if (aw_done && w_done) begin
            draw(1, coin);
            if (coin[0]) begin
                bvalid  <= 1'b1;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) mem[wr_addr[11:0] + 12'(b)] <= wr_data[b*8 +: 8];
                end
                draw(4, coin);
                bresp <= (coin[3:0] == 4'd0) ? 2'b10 : 2'b00;
                if (coin[3:0] == 4'd0) err_count <= err_count + 1;
            end
        end
    end
end

endmodule

/* bench/tb_l1c.sv */
`timescale 1ns/1ns

module tb_l1c;

import l1c_pkg::*;

localparam int N_OPS   = 400;
localparam int TIMEOUT = 300;                         // Cycles per wait

logic        clk = 1'b0;
logic        rstn;
logic        core_req;
logic        core_wr;
logic        core_bypass;
logic        core_flush;
addr_t       core_vaddr;
addr_t       core_paddr;
word_t       core_wdata;
strb_t       core_byte;
word_t       core_rdata;
logic [1:0]  core_bad;
logic        core_busy;
addr_t       m_araddr;
logic [7:0]  m_arlen;
logic        m_arvalid;
logic        m_arready;
word_t       m_rdata;
logic [1:0]  m_rresp;
logic        m_rlast;
logic        m_rvalid;
addr_t       m_awaddr;
logic        m_awvalid;
logic        m_awready;
word_t       m_wdata;
strb_t       m_wstrb;
logic        m_wvalid;
logic        m_wready;
logic [1:0]  m_bresp;
logic        m_bvalid;

logic [15:0] lfsr;
int          errors;
int          timeouts;

// Reference cache
logic        cvalid [64];
tag_t        ctag   [64];
word_t       cword  [64][4];

always #5 clk = ~clk;

l1c dut0 (.*);

axi_mem_slave #(.SEED(16'd36)) slave0 (
    .clk     ( clk       ),
    .rstn    ( rstn      ),
    .araddr  ( m_araddr  ),
    .arlen   ( m_arlen   ),
    .arvalid ( m_arvalid ),
    .arready ( m_arready ),
    .rdata   ( m_rdata   ),
    .rresp   ( m_rresp   ),
    .rlast   ( m_rlast   ),
    .rvalid  ( m_rvalid  ),
    .awaddr  ( m_awaddr  ),
    .awvalid ( m_awvalid ),
    .awready ( m_awready ),
    .wdata   ( m_wdata   ),
    .wstrb   ( m_wstrb   ),
    .wvalid  ( m_wvalid  ),
    .wready  ( m_wready  ),
    .bresp   ( m_bresp   ),
    .bvalid  ( m_bvalid  )
);

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v = {v[30:0], lfsr[0]};
    end
endtask

function automatic word_t mem_word(input addr_t a);
    logic [11:0] b;
    b = {a[11:2], 2'b00};
    return {slave0.mem[b + 12'd3], slave0.mem[b + 12'd2], slave0.mem[b + 12'd1], slave0.mem[b]};
endfunction

function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t s);
    word_t w;
    w = old;
    for (int b = 0; b < 4; b++) begin
        if (s[b]) w[b*8 +: 8] = nw[b*8 +: 8];
    end
    return w;
endfunction

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("FAIL %s got %h expected %h", name, got, exp);
    end
endtask

// Samples at falling edges, where DUT outputs are settled
task automatic wait_idle(output logic first_busy);
    int cycles;
    @(negedge clk);
    first_busy = core_busy;
    cycles = 0;
    while (core_busy && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (core_busy) begin
        $display("Timeout: core_busy stayed high after a request");
        timeouts++;
    end
endtask

task automatic do_access(input logic wr, input logic byp, input addr_t a,
                         input word_t wd, input strb_t st);
    int    ar0;
    int    er0;
    logic  hit_exp;
    logic  first_busy;
    logic  err_exp;
    idx_t  ix;
    tag_t  tg;
    wsel_t ws;
    ix = a[9:4];
    tg = a[31:10];
    ws = a[3:2];
    ar0 = slave0.ar_count;
    er0 = slave0.err_count;
    hit_exp = cvalid[ix] && ctag[ix] == tg;
    @(posedge clk);
    core_req    <= 1'b1;
    core_wr     <= wr;
    core_bypass <= byp;
    core_vaddr  <= a;
    core_paddr  <= a;
    core_wdata  <= wd;
    core_byte   <= st;
    @(posedge clk);
    core_req    <= 1'b0;                              // Accepted at this edge
    wait_idle(first_busy);
    if (timeouts != 0) return;
    err_exp = slave0.err_count != er0;
    compare("core_bad", 32'(core_bad), {30'd0, err_exp, 1'b0});
    if (wr) begin
        compare("m_awaddr", slave0.wr_addr, a);
        compare("m_wdata", slave0.wr_data, wd);
        compare("m_wstrb", 32'(slave0.wr_strb), 32'(st));
        if (hit_exp) cword[ix][ws] = merge_bytes(cword[ix][ws], wd, st);
    end
    else if (!byp) begin
        compare("core_busy", 32'(first_busy), 32'(!hit_exp));
        if (hit_exp) begin
            compare("ar_count", 32'(slave0.ar_count), 32'(ar0));
            compare("core_rdata", core_rdata, cword[ix][ws]);
        end
        else begin
            compare("ar_count", 32'(slave0.ar_count), 32'(ar0 + 1));
            compare("m_araddr", slave0.rd_addr, {a[31:4], 4'h0});
            compare("m_arlen", 32'(slave0.rd_len), 32'd3);
            if (err_exp) begin
                cvalid[ix] = 1'b0;                    // Failed refill leaves the set empty
            end
            else begin
                compare("core_rdata", core_rdata, mem_word(a));
                cvalid[ix] = 1'b1;
                ctag[ix]   = tg;
                for (int w = 0; w < 4; w++) begin
                    cword[ix][w] = mem_word({a[31:4], 2'(w), 2'b00});
                end
            end
        end
    end
    else begin
        compare("ar_count", 32'(slave0.ar_count), 32'(ar0 + 1));
        compare("m_araddr", slave0.rd_addr, a);
        compare("m_arlen", 32'(slave0.rd_len), 32'd0);
        if (!err_exp) compare("core_rdata", core_rdata, mem_word(a));
    end
endtask

task automatic flush_all;
    @(posedge clk);
    core_flush <= 1'b1;
    @(posedge clk);
    core_flush <= 1'b0;
    for (int i = 0; i < 64; i++) cvalid[i] = 1'b0;
    @(negedge clk);
endtask

initial begin
    logic [31:0] op;
    logic [31:0] ab;
    logic [31:0] wd;
    logic [31:0] st;
    addr_t       a;
    rstn        = 1'b0;
    core_req    = 1'b0;
    core_wr     = 1'b0;
    core_bypass = 1'b0;
    core_flush  = 1'b0;
    core_vaddr  = '0;
    core_paddr  = '0;
    core_wdata  = '0;
    core_byte   = '0;
    lfsr        = 16'd36;
    errors      = 0;
    timeouts    = 0;
    for (int i = 0; i < 64; i++) cvalid[i] = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    for (int n = 0; n < N_OPS && timeouts == 0; n++) begin
        take_bits(4, op);
        take_bits(7, ab);
        // Tag bits 11:10, set bits 6:4 and word bits 3:2 keep hits and conflicts frequent
        a = {20'd0, ab[6:5], 3'b000, ab[4:2], ab[1:0], 2'b00};
        if (op < 8 || op == 15) begin
            do_access(1'b0, 1'b0, a, '0, '0);
            do_access(1'b0, 1'b0, a ^ 32'h4, '0, '0);
        end
        else if (op < 10) begin
            do_access(1'b0, 1'b1, a, '0, '0);
        end
        else if (op < 14) begin
            take_bits(32, wd);
            take_bits(4, st);
            do_access(1'b1, 1'b0, a, wd, st[3:0]);
        end
        else begin
            flush_all();
            do_access(1'b0, 1'b0, a, '0, '0);
        end
    end
    $display("errors: %0d timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("sim passed");
    end
    else begin
        $display("sim failed");
    end
    $finish;
end

endmodule

/* tb.f */
verilog/l1c_pkg.sv
verilog/sync_ram.sv
verilog/beat_counter.sv
verilog/l1c_ctrl.sv
verilog/l1c_datapath.sv
verilog/l1c.sv
bench/axi_mem_slave.sv
bench/tb_l1c.sv

/* Makefile */
TOP       ?= tb_l1c
VERILATOR ?= verilator
SEED_ARGS ?= +verilator+seed+36
LOG       ?= sim.log

FILELIST  := tb.f
SRCS      := $(shell cat $(FILELIST))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir

run: $(BIN)
	./$(BIN) $(SEED_ARGS) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
